//--- build.f
source/ex_pkg.sv
source/ex_issue.sv
source/ex_func_unit.sv
source/ex_lane.sv
source/ex_retire.sv
source/ex_cluster_top.sv
dv/ex_tb.sv

//--- Bender.yml
package:
  name: ex_cluster

sources:
  - files:
      - source/ex_pkg.sv
      - source/ex_issue.sv
      - source/ex_func_unit.sv
      - source/ex_lane.sv
      - source/ex_retire.sv
      - source/ex_cluster_top.sv
  - target: simulation
    files:
      - dv/ex_tb.sv

//--- dv/ex_tb.sv
`default_nettype none

module ex_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int lanes = 3;
  localparam int dw = ex_pkg::data_w;
  localparam int rw = ex_pkg::dr_w;
  localparam int num_uops = 600;
  localparam int clk_period = 20;
  // 40 cycles per micro-op before the run counts as hung
  localparam int timeout_ns = num_uops * 40 * clk_period;

  typedef struct packed {
    logic [dw-1:0] result;
    logic [dw-1:0] flags;
    logic [rw-1:0] dr;
    logic          ld_dst;
    logic          ld_acc;
  } rec_t;

  logic              CLK;
  logic              reset;
  logic              in_valid;
  logic              in_ready;
  ex_pkg::uop_kind_e in_kind;
  ex_pkg::uop_op_u   in_op;
  logic [dw-1:0]     in_a;
  logic [dw-1:0]     in_b;
  logic [dw-1:0]     in_c;
  logic [rw-1:0]     in_dr;
  logic              in_cf;
  logic              out_valid;
  logic              out_ready;
  logic [dw-1:0]     out_result;
  logic [dw-1:0]     out_flags;
  logic [rw-1:0]     out_dr;
  logic              out_ld_dst;
  logic              out_ld_acc;

  rec_t   exp_q[$];
  rec_t   exp_rec;
  rec_t   got_rec;
  int     errors;
  int     n_in;
  int     n_out;
  int     n_offered;
  int     cycle;
  logic   taken;
  integer seed;

  ex_cluster_top dut (
    .CLK        (CLK),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_kind    (in_kind),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_c       (in_c),
    .in_dr      (in_dr),
    .in_cf      (in_cf),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .out_flags  (out_flags),
    .out_dr     (out_dr),
    .out_ld_dst (out_ld_dst),
    .out_ld_acc (out_ld_acc)
  );

  initial begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
  end

  function automatic longint sign_extend(input logic [dw-1:0] x);
    return longint'($signed(x));
  endfunction

  // expected record straight from the eflags and cmpxchg rules
  function automatic rec_t expect_uop(input ex_pkg::uop_kind_e kind, input logic [7:0] op,
                                      input logic [dw-1:0] a, input logic [dw-1:0] b,
                                      input logic [dw-1:0] c, input logic [rw-1:0] dr,
                                      input logic cf_in);
    rec_t            e;
    logic [dw-1:0]   y;
    logic [dw-1:0]   fr;
    longint unsigned u;
    longint          s;
    logic            carry;
    logic            cf;
    logic            of;
    int              n;
    e = '0;
    e.dr = dr;
    e.ld_dst = 1'b1;
    cf = 1'b0;
    of = 1'b0;
    fr = '0;
    case (kind)
      ex_pkg::KIND_ALU: begin
        y = op[3] ? c : b;
        case (ex_pkg::alu_op_e'(op[2:0]))
          ex_pkg::ADD, ex_pkg::ADC: begin
            carry = (op[2:0] == ex_pkg::ADC) && cf_in;
            u = longint'(a) + longint'(y) + carry;
            fr = u[dw-1:0];
            cf = u[dw];
            s = sign_extend(a) + sign_extend(y) + carry;
            of = (s != sign_extend(fr));
          end
          ex_pkg::SUB, ex_pkg::CMP: begin
            fr = a - y;
            cf = (a < y);
            s = sign_extend(a) - sign_extend(y);
            of = (s != sign_extend(fr));
            e.ld_dst = (op[2:0] != ex_pkg::CMP);
          end
          ex_pkg::AND: fr = a & y;
          ex_pkg::OR: fr = a | y;
          ex_pkg::XOR: fr = a ^ y;
          default: fr = y;
        endcase
      end
      ex_pkg::KIND_SHIFT: begin
        n = (op[5:1] == 5'd0) ? int'(b[4:0]) : int'(op[5:1]);
        fr = a;
        // one bit per step, cf keeps the last bit out
        for (int i = 0; i < n; i++) begin
          if (op[0]) begin
            cf = fr[0];
            fr = fr >> 1;
          end else begin
            cf = fr[dw-1];
            fr = fr << 1;
          end
        end
      end
      default: begin
        // accumulator in c compared against destination a
        fr = c - a;
        cf = (c < a);
        s = sign_extend(c) - sign_extend(a);
        of = (s != sign_extend(fr));
      end
    endcase
    e.result = fr;
    if (kind == ex_pkg::KIND_CMPXCHG) begin
      e.result = (c == a) ? b : a;
      e.ld_dst = (c == a);
      e.ld_acc = (c != a);
    end
    e.flags[ex_pkg::flag_cf] = cf;
    e.flags[ex_pkg::flag_zf] = (fr == '0);
    e.flags[ex_pkg::flag_sf] = fr[dw-1];
    e.flags[ex_pkg::flag_of] = of;
    return e;
  endfunction

  task automatic drive_uop();
    logic [1:0] k;
    logic [7:0] op_bits;
    k = 2'($random(seed));
    if (k == 2'd3) begin
      k = 2'd0;
    end
    op_bits = 8'($random(seed));
    if (($random(seed) & 3) == 0) begin
      op_bits[5:1] = '0;
    end
    in_kind = ex_pkg::uop_kind_e'(k);
    in_op = ex_pkg::uop_op_u'(op_bits);
    in_a = $random(seed);
    in_b = $random(seed);
    in_c = $random(seed);
    // equal operands now and then for zero results and cmpxchg hits
    if (($random(seed) & 3) == 0) begin
      in_b = in_a;
    end
    if (($random(seed) & 1) == 0) begin
      in_c = in_a;
    end
    if (($random(seed) & 7) == 0) begin
      in_b[4:0] = '0;
    end
    in_dr = rw'($random(seed));
    in_cf = 1'($random(seed));
  endtask

  // scoreboard, sampled at the rising edge
  always @(posedge CLK) begin
    if (reset) begin
      taken = 1'b0;
    end else begin
      assert (out_valid == (exp_q.size() != 0)) else begin
        errors = errors + 1;
        $display("Error at %0t: out_valid=%b with %0d results pending", $time, out_valid,
                 exp_q.size());
      end
      assert (exp_q.size() >= lanes || in_ready) else begin
        errors = errors + 1;
        $display("Error at %0t: in_ready low with a free lane", $time);
      end
      assert (exp_q.size() < lanes || out_ready || !in_ready) else begin
        errors = errors + 1;
        $display("Error at %0t: in_ready high with all lanes held", $time);
      end
      if (out_valid && out_ready && exp_q.size() != 0) begin
        exp_rec = exp_q.pop_front();
        got_rec = {out_result, out_flags, out_dr, out_ld_dst, out_ld_acc};
        assert (got_rec.result == exp_rec.result && got_rec.flags == exp_rec.flags) else begin
          errors = errors + 1;
          $display("Error at %0t: result %h flags %h, expected %h flags %h", $time,
                   got_rec.result, got_rec.flags, exp_rec.result, exp_rec.flags);
        end
        assert (got_rec[rw+1:0] == exp_rec[rw+1:0]) else begin
          errors = errors + 1;
          $display("Error at %0t: dr/ld_dst/ld_acc %b, expected %b", $time,
                   got_rec[rw+1:0], exp_rec[rw+1:0]);
        end
        n_out = n_out + 1;
      end
      taken = in_valid && in_ready;
      if (taken) begin
        exp_q.push_back(expect_uop(in_kind, in_op, in_a, in_b, in_c, in_dr, in_cf));
        n_in = n_in + 1;
      end
    end
  end

  a_out_stable : assert property (
    @(posedge CLK) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_flags)
      && $stable(out_dr) && $stable(out_ld_dst) && $stable(out_ld_acc)
  ) else begin
    errors = errors + 1;
    $display("Error at %0t: writeback port changed while stalled", $time);
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns, the cluster stopped making progress", timeout_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    seed = 32'h65c7b83d;
    errors = 0;
    n_in = 0;
    n_out = 0;
    n_offered = 0;
    cycle = 0;
    taken = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_kind = ex_pkg::KIND_ALU;
    in_op = '0;
    in_a = '0;
    in_b = '0;
    in_c = '0;
    in_dr = '0;
    in_cf = 1'b0;
    out_ready = 1'b0;
    repeat (10) @(negedge CLK);
    reset = 1'b0;
    assert (!out_valid && in_ready) else begin
      errors = errors + 1;
      $display("Error at %0t: after reset out_valid=%b in_ready=%b", $time, out_valid, in_ready);
    end
    while (n_out < num_uops) begin
      @(negedge CLK);
      cycle = cycle + 1;
      // every fourth window of 50 cycles the writeback side mostly stalls
      if ((cycle / 50) % 4 == 2) begin
        out_ready = (($random(seed) & 7) == 0);
      end else begin
        out_ready = (($random(seed) & 3) != 0);
      end
      if (!in_valid || taken) begin
        in_valid = 1'b0;
        if (n_offered < num_uops && ($random(seed) & 3) != 0) begin
          drive_uop();
          in_valid = 1'b1;
          n_offered = n_offered + 1;
        end
      end
    end
    in_valid = 1'b0;
    repeat (4) @(negedge CLK);
    assert (exp_q.size() == 0 && n_in == num_uops && !out_valid) else begin
      errors = errors + 1;
      $display("Error at %0t: %0d results left over, %0d accepted", $time, exp_q.size(), n_in);
    end
    $display("errors=%0d accepted=%0d retired=%0d", errors, n_in, n_out);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/ex_cluster_top.sv
`default_nettype none

module ex_cluster_top #(
  parameter int lanes = 3
) (
  input  wire                          CLK,
  input  wire                          reset,
  input  wire                          in_valid,
  output logic                         in_ready,
  input  wire ex_pkg::uop_kind_e       in_kind,
  input  wire ex_pkg::uop_op_u         in_op,
  input  wire [ex_pkg::data_w-1:0]     in_a,
  input  wire [ex_pkg::data_w-1:0]     in_b,
  input  wire [ex_pkg::data_w-1:0]     in_c,
  input  wire [ex_pkg::dr_w-1:0]       in_dr,
  input  wire                          in_cf,
  output logic                         out_valid,
  input  wire                          out_ready,
  output logic [ex_pkg::data_w-1:0]    out_result,
  output logic [ex_pkg::data_w-1:0]    out_flags,
  output logic [ex_pkg::dr_w-1:0]      out_dr,
  output logic                         out_ld_dst,
  output logic                         out_ld_acc
);

  localparam int dw = ex_pkg::data_w;
  localparam int rw = ex_pkg::dr_w;

  wire [lanes-1:0]    lane_valid;
  wire [lanes-1:0]    lane_ready;
  wire [lanes-1:0]    res_valid;
  wire [lanes-1:0]    res_ready;
  wire [lanes*dw-1:0] res_result;
  wire [lanes*dw-1:0] res_flags;
  wire [lanes*rw-1:0] res_dr;
  wire [lanes-1:0]    res_ld_dst;
  wire [lanes-1:0]    res_ld_acc;

  ex_issue #(
    .lanes (lanes)
  ) u_issue (
    .CLK        (CLK),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready)
  );

  // micro-op fields are broadcast, lane_valid picks the taker
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    ex_lane u_lane (
      .CLK        (CLK),
      .reset      (reset),
      .up_valid   (lane_valid[i]),
      .up_ready   (lane_ready[i]),
      .kind       (in_kind),
      .op         (in_op),
      .a          (in_a),
      .b          (in_b),
      .c          (in_c),
      .dr         (in_dr),
      .cf_in      (in_cf),
      .res_valid  (res_valid[i]),
      .res_ready  (res_ready[i]),
      .res_result (res_result[i*dw +: dw]),
      .res_flags  (res_flags[i*dw +: dw]),
      .res_dr     (res_dr[i*rw +: rw]),
      .res_ld_dst (res_ld_dst[i]),
      .res_ld_acc (res_ld_acc[i])
    );
  end

  ex_retire #(
    .lanes (lanes)
  ) u_retire (
    .CLK        (CLK),
    .reset      (reset),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_result (res_result),
    .res_flags  (res_flags),
    .res_dr     (res_dr),
    .res_ld_dst (res_ld_dst),
    .res_ld_acc (res_ld_acc),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .out_flags  (out_flags),
    .out_dr     (out_dr),
    .out_ld_dst (out_ld_dst),
    .out_ld_acc (out_ld_acc)
  );

endmodule

`default_nettype wire

//--- source/ex_retire.sv
`default_nettype none

module ex_retire #(
  parameter int lanes = 3
) (
  input  wire                               CLK,
  input  wire                               reset,
  input  wire  [lanes-1:0]                  res_valid,
  output logic [lanes-1:0]                  res_ready,
  input  wire  [lanes*ex_pkg::data_w-1:0]   res_result,
  input  wire  [lanes*ex_pkg::data_w-1:0]   res_flags,
  input  wire  [lanes*ex_pkg::dr_w-1:0]     res_dr,
  input  wire  [lanes-1:0]                  res_ld_dst,
  input  wire  [lanes-1:0]                  res_ld_acc,
  output logic                              out_valid,
  input  wire                               out_ready,
  output logic [ex_pkg::data_w-1:0]         out_result,
  output logic [ex_pkg::data_w-1:0]         out_flags,
  output logic [ex_pkg::dr_w-1:0]           out_dr,
  output logic                              out_ld_dst,
  output logic                              out_ld_acc
);

  localparam int ptr_w = $clog2(lanes);
  localparam int dw = ex_pkg::data_w;
  localparam int rw = ex_pkg::dr_w;

  // oldest lane, walks the same order as issue
  logic [ptr_w-1:0] ptr;
  logic             xfer;

  assign out_valid = res_valid[ptr];
  assign out_result = res_result[ptr*dw +: dw];
  assign out_flags = res_flags[ptr*dw +: dw];
  assign out_dr = res_dr[ptr*rw +: rw];
  assign out_ld_dst = res_ld_dst[ptr];
  assign out_ld_acc = res_ld_acc[ptr];

  assign xfer = out_valid && out_ready;

  // drain strobe reaches the head lane only
  always_comb begin
    res_ready = '0;
    res_ready[ptr] = out_ready;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      ptr <= '0;
    end else if (xfer) begin
      if (ptr == ptr_w'(lanes - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // the writeback port never withdraws an offered result
  a_out_hold : assert property (
    @(posedge CLK) disable iff (reset)
    out_valid && !out_ready |=> out_valid
  );

endmodule

`default_nettype wire

//--- source/ex_lane.sv
`default_nettype none

module ex_lane (
  input  wire                          CLK,
  input  wire                          reset,
  input  wire                          up_valid,
  output logic                         up_ready,
  input  wire ex_pkg::uop_kind_e       kind,
  input  wire ex_pkg::uop_op_u         op,
  input  wire [ex_pkg::data_w-1:0]     a,
  input  wire [ex_pkg::data_w-1:0]     b,
  input  wire [ex_pkg::data_w-1:0]     c,
  input  wire [ex_pkg::dr_w-1:0]       dr,
  input  wire                          cf_in,
  output logic                         res_valid,
  input  wire                          res_ready,
  output logic [ex_pkg::data_w-1:0]    res_result,
  output logic [ex_pkg::data_w-1:0]    res_flags,
  output logic [ex_pkg::dr_w-1:0]      res_dr,
  output logic                         res_ld_dst,
  output logic                         res_ld_acc
);

  localparam int dw = ex_pkg::data_w;

  logic [dw-1:0] fu_a;
  logic [dw-1:0] fu_b;
  logic [dw-1:0] fu_result;
  logic [dw-1:0] fu_flags;
  logic [dw-1:0] nxt_result;
  logic          nxt_ld_dst;
  logic          nxt_ld_acc;
  logic          load;

  // operand select
  always_comb begin
    fu_a = a;
    fu_b = b;
    case (kind)
      ex_pkg::KIND_ALU: begin
        if (op.alu.imm_sel) begin
          fu_b = c;
        end
      end
      // accumulator rides in on c and is compared with the destination
      ex_pkg::KIND_CMPXCHG: begin
        fu_a = c;
        fu_b = a;
      end
      default: ;
    endcase
  end

  ex_func_unit u_func_unit (
    .kind   (kind),
    .op     (op),
    .a      (fu_a),
    .b      (fu_b),
    .cf_in  (cf_in),
    .result (fu_result),
    .flags  (fu_flags)
  );

  // cmpxchg decision and write enables
  always_comb begin
    nxt_result = fu_result;
    nxt_ld_dst = 1'b1;
    nxt_ld_acc = 1'b0;
    if (kind == ex_pkg::KIND_CMPXCHG) begin
      if (fu_flags[ex_pkg::flag_zf]) begin
        nxt_result = b;
      end else begin
        nxt_result = a;
        nxt_ld_dst = 1'b0;
        nxt_ld_acc = 1'b1;
      end
    end else if (kind == ex_pkg::KIND_ALU && op.alu.func == ex_pkg::CMP) begin
      nxt_ld_dst = 1'b0;
    end
  end

  // one-entry result slot, refills in the cycle it drains
  assign up_ready = !res_valid || res_ready;
  assign load = up_valid && up_ready;

  always_ff @(posedge CLK) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else if (load) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      res_result <= nxt_result;
      res_flags <= fu_flags;
      res_dr <= dr;
      res_ld_dst <= nxt_ld_dst;
      res_ld_acc <= nxt_ld_acc;
    end
  end

  // a parked result stays put until retire takes it
  a_hold_result : assert property (
    @(posedge CLK) disable iff (reset)
    res_valid && !res_ready |=> res_valid && $stable(res_result) && $stable(res_flags)
  );

endmodule

`default_nettype wire

//--- source/ex_func_unit.sv
`default_nettype none

module ex_func_unit (
  input  wire ex_pkg::uop_kind_e        kind,
  input  wire ex_pkg::uop_op_u          op,
  input  wire [ex_pkg::data_w-1:0]      a,
  input  wire [ex_pkg::data_w-1:0]      b,
  input  wire                           cf_in,
  output logic [ex_pkg::data_w-1:0]     result,
  output logic [ex_pkg::data_w-1:0]     flags
);

  localparam int dw = ex_pkg::data_w;

  // one spare bit on top (or bottom) catches carry, borrow or shift-out
  logic [dw:0] wide;
  logic [4:0]  count;
  logic        carry;
  logic        cf;
  logic        of;

  always_comb begin
    wide = '0;
    carry = 1'b0;
    cf = 1'b0;
    of = 1'b0;
    result = '0;
    count = op.shift.count;
    case (kind)
      ex_pkg::KIND_SHIFT: begin
        if (count == '0) begin
          count = b[4:0];
        end
        // count of zero shifts nothing into the spare bit, so cf stays 0
        if (op.shift.dir) begin
          wide = {a, 1'b0} >> count;
          result = wide[dw:1];
          cf = wide[0];
        end else begin
          wide = {1'b0, a} << count;
          result = wide[dw-1:0];
          cf = wide[dw];
        end
      end
      ex_pkg::KIND_ALU: begin
        case (op.alu.func)
          ex_pkg::ADD, ex_pkg::ADC: begin
            carry = (op.alu.func == ex_pkg::ADC) && cf_in;
            wide = {1'b0, a} + {1'b0, b} + {{dw{1'b0}}, carry};
            result = wide[dw-1:0];
            cf = wide[dw];
            of = (a[dw-1] == b[dw-1]) && (result[dw-1] != a[dw-1]);
          end
          ex_pkg::SUB, ex_pkg::CMP: begin
            wide = {1'b0, a} - {1'b0, b};
            result = wide[dw-1:0];
            cf = wide[dw];
            of = (a[dw-1] != b[dw-1]) && (result[dw-1] != a[dw-1]);
          end
          ex_pkg::AND: result = a & b;
          ex_pkg::OR: result = a | b;
          ex_pkg::XOR: result = a ^ b;
          default: result = b;
        endcase
      end
      default: begin
        // cmpxchg compare, same flags as subtract
        wide = {1'b0, a} - {1'b0, b};
        result = wide[dw-1:0];
        cf = wide[dw];
        of = (a[dw-1] != b[dw-1]) && (result[dw-1] != a[dw-1]);
      end
    endcase

    flags = '0;
    flags[ex_pkg::flag_cf] = cf;
    flags[ex_pkg::flag_zf] = (result == '0);
    flags[ex_pkg::flag_sf] = result[dw-1];
    flags[ex_pkg::flag_of] = of;
  end

endmodule

`default_nettype wire

//--- source/ex_issue.sv
`default_nettype none

module ex_issue #(
  parameter int lanes = 3
) (
  input  wire              CLK,
  input  wire              reset,
  input  wire              in_valid,
  output logic             in_ready,
  output logic [lanes-1:0] lane_valid,
  input  wire  [lanes-1:0] lane_ready
);

  localparam int ptr_w = $clog2(lanes);

  // next lane to receive a micro-op
  logic [ptr_w-1:0] ptr;
  logic             xfer;

  assign xfer = in_valid && in_ready;

  // back-pressure follows the selected lane only
  assign in_ready = lane_ready[ptr];

  always_comb begin
    lane_valid = '0;
    lane_valid[ptr] = in_valid;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      ptr <= '0;
    end else if (xfer) begin
      // wrap at lanes, which need not be a power of two
      if (ptr == ptr_w'(lanes - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // pointer never lands on a lane that does not exist
  a_ptr_range : assert property (
    @(posedge CLK) disable iff (reset)
    ptr < lanes
  );

endmodule

`default_nettype wire

//--- source/ex_pkg.sv
`default_nettype none

package ex_pkg;

  // datapath widths
  localparam int data_w = 32;
  localparam int dr_w = 3;

  // micro-op class, picks which view of the op byte is live
  typedef enum logic [1:0] {
    KIND_ALU,
    KIND_SHIFT,
    KIND_CMPXCHG
  } uop_kind_e;

  typedef enum logic [2:0] {
    ADD,
    ADC,
    SUB,
    CMP,
    AND,
    OR,
    XOR,
    PASS_B
  } alu_op_e;

  // alu view: imm_sel takes operand c in place of b
  typedef struct packed {
    logic [3:0] rsvd;
    logic       imm_sel;
    alu_op_e    func;
  } alu_view_t;

  // shift view: dir 0 is left, count 0 means use b[4:0]
  typedef struct packed {
    logic [1:0] rsvd;
    logic [4:0] count;
    logic       dir;
  } shift_view_t;

  typedef union packed {
    alu_view_t   alu;
    shift_view_t shift;
  } uop_op_u;

  // eflags bit positions
  localparam int flag_cf = 0;
  localparam int flag_zf = 6;
  localparam int flag_sf = 7;
  localparam int flag_of = 11;

endpackage

`default_nettype wire
